// File: Makefile
# Verilator build, run and lint for the pe_cntl testbench

VERILATOR  ?= verilator
TOP        ?= tb_pe_cntl
RTL_TOP    ?= pe_cntl
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= SIMULATION PASSED

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard tests/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/pe_cntl_pkg.sv
package pe_cntl_pkg;

  // --------------------------------------------------
  // OOB word layout
  // --------------------------------------------------

  localparam int OOB_DATA_W = 32;                    // One OOB word per cycle
  localparam int TUPLE_W    = 16;                    // Two tuples per word, tuple 0 in the low half
  localparam int OPTION_W   = 4;                     // Option code sits in the top of a tuple
  localparam int VALUE_W    = TUPLE_W - OPTION_W;

  // Option codes
  localparam logic [OPTION_W-1:0] OPTION_STOP = 4'h2;  // Value is a streaming-op pointer

  typedef logic [OOB_DATA_W-1:0] oob_word_t;

  // One {option, value} tuple
  typedef struct packed
  {
    logic [OPTION_W-1:0] option;
    logic [VALUE_W-1:0]  value;
  } tuple_t;

  // --------------------------------------------------
  // Lane and address geometry
  // --------------------------------------------------

  localparam int NUM_LANES      = 4;
  localparam int LANE_BITS      = $clog2(NUM_LANES);
  localparam int ADDR_W         = 24;
  // Lane number replaces bits [LANE_FIELD_LSB +: LANE_BITS] of a common address
  localparam int LANE_FIELD_LSB = 10;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef addr_t [NUM_LANES-1:0] lane_addr_t;    // Lane 0 in the low slot

endpackage

// File: common/stop_cfg_if.sv
`timescale 1ns/1ns

// Registered streaming-op configuration and its start bit
interface stop_cfg_if;
  import stop_cfg_pkg::*;

  logic      enable;   // Streaming op running
  stop_cfg_t cfg;      // Common configuration for all lanes

  // Configuration registers drive
  modport source
  (
    output enable,
    output cfg
  );

  // Lane fan-out reads
  modport sink
  (
    input enable,
    input cfg
  );

endinterface

// File: common/stop_cfg_pkg.sv
package stop_cfg_pkg;

  // Option memory geometry
  localparam int    ROM_DEPTH = 16;
  localparam int    PTR_W     = $clog2(ROM_DEPTH);  // Low bits of a tuple value
  localparam string ROM_FILE  = "stop_options.hex";

  typedef logic [PTR_W-1:0] ptr_t;

  // Streaming-op field types
  typedef logic [7:0]  operation_t;
  typedef logic [3:0]  data_type_t;      // Bit, nibble, byte, word
  typedef logic [15:0] num_operands_t;

  // One option memory entry, 128 bits, operation at the top
  typedef struct packed
  {
    operation_t         operation;
    pe_cntl_pkg::addr_t src_addr0;
    pe_cntl_pkg::addr_t dst_addr0;
    pe_cntl_pkg::addr_t src_addr1;
    pe_cntl_pkg::addr_t dst_addr1;
    data_type_t         src_type0;
    data_type_t         src_type1;
    num_operands_t      num_operands;
  } stop_cfg_t;

endpackage

// File: design/oob_command_ctrl.sv
`timescale 1ns/1ns

module oob_command_ctrl
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   oob_valid,
  input  pe_cntl_pkg::oob_word_t oob_data,
  input  logic                   stop_complete,
  output logic                   oob_ready,
  output stop_cfg_pkg::ptr_t     ptr,
  output logic                   load,
  output logic                   complete_rise
);
  import pe_cntl_pkg::*;
  import stop_cfg_pkg::*;

  tuple_t tuple0;
  tuple_t tuple1;
  logic   stop_in_t0;
  logic   stop_in_t1;
  logic   accept;
  logic   busy;            // Command in flight
  logic   complete_d1;
  logic   complete_fall;

  // --------------------------------------------------
  // Tuple decode
  // --------------------------------------------------

  assign tuple0 = oob_data[TUPLE_W-1:0];
  assign tuple1 = oob_data[OOB_DATA_W-1:TUPLE_W];

  assign stop_in_t0 = (tuple0.option == OPTION_STOP);
  assign stop_in_t1 = (tuple1.option == OPTION_STOP);

  assign oob_ready = ~busy;
  assign accept    = oob_valid & oob_ready;   // Only one command at a time

  // Tuple 0 wins when both carry a pointer, otherwise keep the old one
  always_ff @(posedge clk)
  begin
    if (reset)
      ptr <= '0;
    else if (accept && stop_in_t0)
      ptr <= tuple0.value[PTR_W-1:0];
    else if (accept && stop_in_t1)
      ptr <= tuple1.value[PTR_W-1:0];
  end

  // --------------------------------------------------
  // Busy tracking and complete edges
  // --------------------------------------------------

  assign complete_rise = stop_complete & ~complete_d1;
  assign complete_fall = ~stop_complete & complete_d1;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy        <= 1'b0;
      load        <= 1'b0;
      complete_d1 <= 1'b0;
    end
    else
    begin
      load        <= accept;            // Pointer is valid the cycle after accept
      complete_d1 <= stop_complete;
      if (accept)
        busy <= 1'b1;
      else if (complete_fall)
        busy <= 1'b0;                   // Streaming op is idle again
    end
  end

endmodule

// File: design/pe_cntl.sv
`timescale 1ns/1ns

module pe_cntl
(
  input  logic                        clk,
  input  logic                        reset,

  // OOB command stream
  input  logic                        oob_valid,
  input  pe_cntl_pkg::oob_word_t      oob_data,
  output logic                        oob_ready,

  // Streaming op control
  input  logic                        stop_complete,
  output logic                        stop_enable,
  output stop_cfg_pkg::operation_t    stop_operation,
  output pe_cntl_pkg::lane_addr_t     lane_src_addr0,
  output pe_cntl_pkg::lane_addr_t     lane_dst_addr0,
  output pe_cntl_pkg::lane_addr_t     lane_src_addr1,
  output pe_cntl_pkg::lane_addr_t     lane_dst_addr1,
  output stop_cfg_pkg::data_type_t    src_type0,
  output stop_cfg_pkg::data_type_t    src_type1,
  output stop_cfg_pkg::num_operands_t num_operands
);
  import pe_cntl_pkg::*;
  import stop_cfg_pkg::*;

  ptr_t      ptr;
  logic      load;
  logic      complete_rise;
  stop_cfg_t entry;

  stop_cfg_if cfg_bus ();

  // Lane number goes into the fixed lane field of a common address
  function automatic addr_t insert_lane(addr_t addr, logic [LANE_BITS-1:0] lane);
    addr_t result;
    result = addr;
    result[LANE_FIELD_LSB +: LANE_BITS] = lane;
    return result;
  endfunction

  // --------------------------------------------------
  // Command path
  // --------------------------------------------------

  oob_command_ctrl u_oob_command_ctrl
  (
    .clk           (clk),
    .reset         (reset),
    .oob_valid     (oob_valid),
    .oob_data      (oob_data),
    .stop_complete (stop_complete),
    .oob_ready     (oob_ready),
    .ptr           (ptr),
    .load          (load),
    .complete_rise (complete_rise)
  );

  stop_option_rom u_stop_option_rom
  (
    .ptr   (ptr),
    .entry (entry)
  );

  stop_config_regs u_stop_config_regs
  (
    .clk           (clk),
    .reset         (reset),
    .load          (load),
    .complete_rise (complete_rise),
    .entry         (entry),
    .cfg_out       (cfg_bus)
  );

  // --------------------------------------------------
  // Fan-out to the execution lanes
  // --------------------------------------------------

  assign stop_enable    = cfg_bus.enable;
  assign stop_operation = cfg_bus.cfg.operation;
  assign src_type0      = cfg_bus.cfg.src_type0;      // Same for every lane
  assign src_type1      = cfg_bus.cfg.src_type1;
  assign num_operands   = cfg_bus.cfg.num_operands;

  for (genvar lane = 0; lane < NUM_LANES; lane++)
  begin : g_lane
    localparam logic [LANE_BITS-1:0] LANE_ID = LANE_BITS'(lane);

    assign lane_src_addr0[lane] = insert_lane(cfg_bus.cfg.src_addr0, LANE_ID);
    assign lane_dst_addr0[lane] = insert_lane(cfg_bus.cfg.dst_addr0, LANE_ID);
    assign lane_src_addr1[lane] = insert_lane(cfg_bus.cfg.src_addr1, LANE_ID);
    assign lane_dst_addr1[lane] = insert_lane(cfg_bus.cfg.dst_addr1, LANE_ID);
  end

endmodule

// File: design/stop_config_regs.sv
`timescale 1ns/1ns

module stop_config_regs
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    load,
  input  logic                    complete_rise,
  input  stop_cfg_pkg::stop_cfg_t entry,
  stop_cfg_if.source              cfg_out
);
  import stop_cfg_pkg::*;

  logic      enable_q;
  stop_cfg_t cfg_q;

  // --------------------------------------------------
  // Configuration capture
  // --------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      cfg_q <= '0;
    else if (load)
      cfg_q <= entry;       // Held until the next command
  end

  // Start bit, a new command beats a late complete
  always_ff @(posedge clk)
  begin
    if (reset)
      enable_q <= 1'b0;
    else if (load)
      enable_q <= 1'b1;
    else if (complete_rise)
      enable_q <= 1'b0;
  end

  assign cfg_out.enable = enable_q;
  assign cfg_out.cfg    = cfg_q;

endmodule

// File: design/stop_option_rom.sv
`timescale 1ns/1ns

module stop_option_rom
(
  input  stop_cfg_pkg::ptr_t      ptr,
  output stop_cfg_pkg::stop_cfg_t entry
);
  import stop_cfg_pkg::*;

  // One packed entry per word, same layout as stop_cfg_t
  logic [$bits(stop_cfg_t)-1:0] mem [ROM_DEPTH];

  // Contents are preloaded once and never written
  initial
  begin
    $readmemh(ROM_FILE, mem);
  end

  // Combinational read
  assign entry = stop_cfg_t'(mem[ptr]);

endmodule

// File: stop_options.hex
// operation src_addr0 dst_addr0 src_addr1 dst_addr1 src_type0 src_type1 num_operands
// One 128-bit entry per line, 32 hex digits, pointer 0 first
a0000c10011420022830033f40030008
a1100c11111421122831133f41130018
a2200c12211422222832233f42230028
a3300c13311423322833333f43330038
a4400c14411424422834433f44430048
a5500c15511425522835533f45530058
a6600c16611426622836633f46630068
a7700c17711427722837733f47730078
a8800c18811428822838833f48830088
a9900c19911429922839933f49930098
aaa00c1aa1142aa2283aa33f4aa300a8
abb00c1bb1142bb2283bb33f4bb300b8
acc00c1cc1142cc2283cc33f4cc300c8
add00c1dd1142dd2283dd33f4dd300d8
aee00c1ee1142ee2283ee33f4ee300e8
aff00c1ff1142ff2283ff33f4ff300f8

// File: tests/tb_pe_cntl_checks.svh
`ifndef TB_PE_CNTL_CHECKS_SVH
`define TB_PE_CNTL_CHECKS_SVH

// --------------------------------------------------
// Expected values
// --------------------------------------------------

// Lane number sits in the lane field, the rest is the common address
function automatic addr_t expect_lane_addr(addr_t common, int lane);
  addr_t field_mask;
  field_mask = addr_t'((1 << LANE_BITS) - 1) << LANE_FIELD_LSB;
  return (common & ~field_mask) | (addr_t'(lane) << LANE_FIELD_LSB);
endfunction

function automatic lane_addr_t expect_lanes(addr_t common);
  lane_addr_t lanes;
  for (int lane = 0; lane < NUM_LANES; lane++)
    lanes[lane] = expect_lane_addr(common, lane);
  return lanes;
endfunction

// Entry as lane 0 sees it
function automatic stop_cfg_t expect_lane0_cfg(stop_cfg_t entry);
  stop_cfg_t cfg;
  cfg           = entry;
  cfg.src_addr0 = expect_lane_addr(entry.src_addr0, 0);
  cfg.dst_addr0 = expect_lane_addr(entry.dst_addr0, 0);
  cfg.src_addr1 = expect_lane_addr(entry.src_addr1, 0);
  cfg.dst_addr1 = expect_lane_addr(entry.dst_addr1, 0);
  return cfg;
endfunction

// DUT outputs gathered into one entry, addresses from lane 0
function automatic stop_cfg_t observed_cfg();
  stop_cfg_t cfg;
  cfg.operation    = stop_operation;
  cfg.src_addr0    = lane_src_addr0[0];
  cfg.dst_addr0    = lane_dst_addr0[0];
  cfg.src_addr1    = lane_src_addr1[0];
  cfg.dst_addr1    = lane_dst_addr1[0];
  cfg.src_type0    = src_type0;
  cfg.src_type1    = src_type1;
  cfg.num_operands = num_operands;
  return cfg;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------

task automatic check_bit(input string name, input string what, input logic exp,
                         input logic act);
  if (act !== exp)
  begin
    error_count++;
    $display("FAILED %s: %s expected %b actual %b", name, what, exp, act);
  end
endtask

task automatic check_cfg(input string name, input stop_cfg_t entry);
  stop_cfg_t exp;
  stop_cfg_t act;
  exp = expect_lane0_cfg(entry);
  act = observed_cfg();
  if (act !== exp)
  begin
    error_count++;
    $display("FAILED %s: configuration expected %h actual %h", name, exp, act);
  end
endtask

task automatic check_lane(input string name, input string what, input lane_addr_t exp,
                          input lane_addr_t act);
  if (act !== exp)
  begin
    error_count++;
    $display("FAILED %s: %s lanes expected %h actual %h", name, what, exp, act);
  end
endtask

// Finds which memory entry is on the outputs, lowest pointer on a tie
task automatic check_ptr_effect(input string name, input ptr_t exp);
  stop_cfg_t act_cfg;
  bit        found;
  ptr_t      act;
  act_cfg = observed_cfg();
  found   = 1'b0;
  act     = '0;
  for (int i = ROM_DEPTH - 1; i >= 0; i--)
  begin
    if (expect_lane0_cfg(stop_cfg_t'(rom_words[i])) == act_cfg)
    begin
      found = 1'b1;
      act   = ptr_t'(i);
    end
  end
  if (!found)
  begin
    error_count++;
    $display("FAILED %s: pointer expected %0d actual none, no entry matches", name, exp);
  end
  else if (act !== exp)
  begin
    error_count++;
    $display("FAILED %s: pointer expected %0d actual %0d", name, exp, act);
  end
endtask

`endif

// File: tests/tb_pe_cntl.sv
`timescale 1ns/1ns

module tb_pe_cntl;
  import pe_cntl_pkg::*;
  import stop_cfg_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_TESTS    = 9;
  localparam int KEEP_PTR     = -1;   // Word without a pointer reloads the previous one
  localparam int WATCHDOG_NS  = NUM_TESTS * 20 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  // --------------------------------------------------
  // Command table with tuple 1 in the upper half
  // --------------------------------------------------

  string test_name [NUM_TESTS] = '{"stop_in_tuple0", "stop_in_tuple1", "both_tuple0_wins",
                                   "no_stop_keeps_ptr", "wide_value_low_bits",
                                   "tuple1_ptr_zero", "no_stop_after_zero",
                                   "tuple0_ptr_15", "tuple1_ptr_14"};

  localparam oob_word_t TEST_WORD [NUM_TESTS] = '{32'h0000_2003, 32'h2009_50aa, 32'h2005_200c,
                                                  32'h300f_1004, 32'h0000_2ff7, 32'h20e0_f002,
                                                  32'h1234_5678, 32'h4002_200f, 32'h200e_3002};

  localparam int TEST_PTR [NUM_TESTS] = '{3, 9, 12, KEEP_PTR, 7, 0, KEEP_PTR, 15, 14};

  logic          clk = 1'b0;
  logic          reset;
  logic          oob_valid;
  oob_word_t     oob_data;
  logic          stop_complete;
  logic          oob_ready;
  logic          stop_enable;
  operation_t    stop_operation;
  lane_addr_t    lane_src_addr0;
  lane_addr_t    lane_dst_addr0;
  lane_addr_t    lane_src_addr1;
  lane_addr_t    lane_dst_addr1;
  data_type_t    src_type0;
  data_type_t    src_type1;
  num_operands_t num_operands;

  logic [$bits(stop_cfg_t)-1:0] rom_words [ROM_DEPTH];   // Reference copy of the memory
  logic [15:0]   lfsr_state;
  int            error_count;
  int            tests_passed;
  int            tests_failed;

  always #(CLK_PERIOD / 2) clk = ~clk;

  pe_cntl u_pe_cntl
  (
    .clk            (clk),
    .reset          (reset),
    .oob_valid      (oob_valid),
    .oob_data       (oob_data),
    .oob_ready      (oob_ready),
    .stop_complete  (stop_complete),
    .stop_enable    (stop_enable),
    .stop_operation (stop_operation),
    .lane_src_addr0 (lane_src_addr0),
    .lane_dst_addr0 (lane_dst_addr0),
    .lane_src_addr1 (lane_src_addr1),
    .lane_dst_addr1 (lane_dst_addr1),
    .src_type0      (src_type0),
    .src_type1      (src_type1),
    .num_operands   (num_operands)
  );

  `include "tb_pe_cntl_checks.svh"

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] state);
    if (state[0])
      return (state >> 1) ^ 16'hb400;
    return state >> 1;
  endfunction

  task automatic draw_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      value      = value * 2 + int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);       // One step per bit
    end
  endtask

  // Pointer command that differs from the one running
  function automatic oob_word_t busy_word(ptr_t running);
    tuple_t t;
    t.option = OPTION_STOP;
    t.value  = VALUE_W'(running ^ 4'h5);
    return {16'h0000, t};
  endfunction

  task automatic report_test(input string name, input int start_errors);
    if (error_count == start_errors)
    begin
      tests_passed++;
      $display("PASS  %s", name);
    end
    else
    begin
      tests_failed++;
      $display("FAIL  %s  (%0d mismatches)", name, error_count - start_errors);
    end
  endtask

  // --------------------------------------------------
  // One table row plus the streaming-op model
  // --------------------------------------------------

  task automatic run_command(input int row, inout ptr_t cur_ptr);
    string     name;
    ptr_t      exp_ptr;
    stop_cfg_t exp_entry;
    int        start_errors;
    int        delay;
    int        hold;

    name         = test_name[row];
    start_errors = error_count;
    exp_ptr      = (TEST_PTR[row] == KEEP_PTR) ? cur_ptr : ptr_t'(TEST_PTR[row]);
    exp_entry    = stop_cfg_t'(rom_words[exp_ptr]);
    draw_bits(3, delay);
    delay = delay + 1;                          // 1 to 8 cycles before complete
    draw_bits(2, hold);
    hold = hold + 1;                            // 1 to 4 cycles of complete

    @(posedge clk);
    oob_valid <= 1'b1;
    oob_data  <= TEST_WORD[row];
    @(negedge clk);
    while (!oob_ready)
    begin
      @(negedge clk);
    end
    @(posedge clk);                             // Accept edge
    oob_valid <= 1'b0;
    @(negedge clk);
    check_bit(name, "oob_ready after accept", 1'b0, oob_ready);
    check_bit(name, "stop_enable before load", 1'b0, stop_enable);
    @(posedge clk);                             // Load edge
    @(negedge clk);
    check_bit(name, "stop_enable after load", 1'b1, stop_enable);
    check_ptr_effect(name, exp_ptr);
    check_cfg(name, exp_entry);
    check_lane(name, "src_addr0", expect_lanes(exp_entry.src_addr0), lane_src_addr0);
    check_lane(name, "dst_addr0", expect_lanes(exp_entry.dst_addr0), lane_dst_addr0);
    check_lane(name, "src_addr1", expect_lanes(exp_entry.src_addr1), lane_src_addr1);
    check_lane(name, "dst_addr1", expect_lanes(exp_entry.dst_addr1), lane_dst_addr1);

    // Streaming op runs while another word waits on the bus
    for (int i = 1; i <= delay; i++)
    begin
      @(posedge clk);
      if (i == 1)
      begin
        oob_valid <= 1'b1;
        oob_data  <= busy_word(exp_ptr);
      end
      if (i == delay)
        stop_complete <= 1'b1;
      @(negedge clk);
      check_bit(name, "stop_enable while running", 1'b1, stop_enable);
      check_bit(name, "oob_ready while busy", 1'b0, oob_ready);
    end

    for (int i = 1; i <= hold; i++)
    begin
      @(posedge clk);
      if (i == hold)
      begin
        stop_complete <= 1'b0;
        oob_valid     <= 1'b0;                  // Producer withdraws the extra word
      end
      @(negedge clk);
      check_bit(name, "stop_enable after complete", 1'b0, stop_enable);
      check_bit(name, "oob_ready during complete", 1'b0, oob_ready);
    end

    @(posedge clk);
    @(negedge clk);
    check_bit(name, "oob_ready after complete falls", 1'b1, oob_ready);
    check_bit(name, "stop_enable when idle", 1'b0, stop_enable);
    check_cfg(name, exp_entry);                 // Outputs hold their values
    cur_ptr = exp_ptr;
    report_test(name, start_errors);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial
  begin
    ptr_t cur_ptr;
    int   start_errors;

    reset         <= 1'b1;
    oob_valid     <= 1'b0;
    oob_data      <= '0;
    stop_complete <= 1'b0;
    lfsr_state   = 16'd24;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    cur_ptr      = '0;
    $readmemh(ROM_FILE, rom_words);

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    start_errors = error_count;
    check_bit("reset_state", "oob_ready", 1'b1, oob_ready);
    check_bit("reset_state", "stop_enable", 1'b0, stop_enable);
    check_cfg("reset_state", '0);
    check_lane("reset_state", "src_addr0", expect_lanes('0), lane_src_addr0);
    check_lane("reset_state", "dst_addr0", expect_lanes('0), lane_dst_addr0);
    check_lane("reset_state", "src_addr1", expect_lanes('0), lane_src_addr1);
    check_lane("reset_state", "dst_addr1", expect_lanes('0), lane_dst_addr1);
    report_test("reset_state", start_errors);

    for (int row = 0; row < NUM_TESTS; row++)
      run_command(row, cur_ptr);

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
    if (error_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, a test never finished", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+tests
common/pe_cntl_pkg.sv
common/stop_cfg_pkg.sv
common/stop_cfg_if.sv
design/oob_command_ctrl.sv
design/stop_option_rom.sv
design/stop_config_regs.sv
design/pe_cntl.sv
tests/tb_pe_cntl.sv
